/* flist.f */
+incdir+logic
logic/dalu_pkg.sv
logic/acc_rd_if.sv
logic/alu_mac.sv
logic/accumulator_file.sv
logic/acc_limiter.sv
logic/status_reg.sv
logic/data_alu.sv
dv/tb_data_alu.sv

/* dv/tb_data_alu.sv */
// ========================================
// testbench for the data ALU slice. a shadow model predicts each
// output one edge ahead and assertions compare at every edge.
// inputs change 1 ns after the rising edge. needs logic/ on +incdir+.
// ========================================
`timescale 1ns/1ps
`include "dalu_settings.svh"

module tb_data_alu;
	import dalu_pkg::*;

	localparam int STIM_CYCLES = 100;  // reset plus all test steps.
	localparam int MAX_CYCLES  = 2 * STIM_CYCLES;
	localparam int AW          = `DALU_ACC_W;

	logic    clk;
	logic    rst_n;
	alu_op_t op;
	logic    dst_sel;
	word_t   x_in;
	word_t   y_in;
	logic    set_scale;
	scale_t  scale_in;
	logic    clr_l;
	logic    rd_en;
	logic    rd_sel;
	logic    rd_lsb;
	word_t   rd_data;
	logic    rd_valid;
	logic    flag_l;
	logic    flag_e;
	logic    flag_n;
	logic    flag_z;
	scale_t  scale_mode;

	logic [AW-1:0] model_acc [2];  // shadow A and B.
	logic [AW-1:0] model_next;     // value the pending command writes.
	scale_t        model_mode;
	word_t         exp_data;
	logic          exp_valid;
	logic          exp_l;
	logic          exp_e;
	logic          exp_n;
	logic          exp_z;
	logic [15:0]   lfsr_q;  // random source.
	int            errors;
	int            cycles;

	data_alu u_dut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;  // 20 ns period.

	// window below the sign, 9 bits wide unscaled, 8 scaled down, 10 scaled up.
	function automatic logic window_busy(input logic [AW-1:0] acc, input scale_t mode);
		int unsigned   width;
		logic [AW-1:0] top;
		width = (mode == SCALE_DOWN) ? 8 : ((mode == SCALE_UP) ? 10 : 9);
		top   = acc >> (AW - width);
		return (top != '0) && (top != ((56'd1 << width) - 56'd1));
	endfunction

	function automatic word_t expect_word(input logic [AW-1:0] acc, input scale_t mode,
			input logic lsb);
		logic [AW-1:0] shifted;
		if (window_busy(acc, mode))
		begin
			if (lsb)
				return acc[AW-1] ? 24'h000000 : 24'hffffff;
			return acc[AW-1] ? 24'h800000 : 24'h7fffff;
		end
		case (mode)
			SCALE_DOWN: shifted = acc >> 1;
			SCALE_UP:   shifted = acc << 1;
			default:    shifted = acc;  // reserved reads unscaled.
		endcase
		return lsb ? shifted[23:0] : shifted[47:24];
	endfunction

	// signed fraction product, one place left, 56 bits.
	function automatic logic [AW-1:0] frac_product(input word_t x, input word_t y);
		logic signed [AW-1:0] xs;
		logic signed [AW-1:0] ys;
		xs = $signed(x);
		ys = $signed(y);
		return (xs * ys) <<< 1;
	endfunction

	function automatic logic [AW-1:0] next_acc(input alu_op_t cmd, input logic [AW-1:0] acc,
			input word_t x, input word_t y);
		case (cmd)
			OP_CLR:  return '0;
			OP_LOAD: return {{32{x[23]}}, x} << 24;  // low word zero.
			OP_MAC:  return acc + frac_product(x, y);
			OP_MSUB: return acc - frac_product(x, y);
			default: return acc;
		endcase
	endfunction

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit taken.
	function automatic logic [23:0] rand_bits(input int n);
		logic [23:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			val    = {val[22:0], fb};
		end
		return val;
	endfunction

	function automatic logic rand_bit();
		logic [23:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	// 20-bit signed operand, keeps sums clear of the extension.
	function automatic word_t small_word();
		logic [23:0] r;
		r = rand_bits(20);
		return {{4{r[19]}}, r[19:0]};
	endfunction

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		errors++;
		$display("FAILED %s expected 0x%06h actual 0x%06h at %0t", name, expected, actual, $time);
	endtask

	// shadow model, same edge as the DUT.
	assign model_next = next_acc(op, model_acc[dst_sel], x_in, y_in);

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			model_acc[0] <= '0;
			model_acc[1] <= '0;
			model_mode   <= SCALE_NONE;
			exp_valid    <= 1'b0;
			exp_l        <= 1'b0;
			exp_e        <= 1'b0;
			exp_n        <= 1'b0;
			exp_z        <= 1'b0;
		end
		else
		begin
			exp_valid <= rd_en;
			if (rd_en)
				exp_data <= expect_word(model_acc[rd_sel], model_mode, rd_lsb);  // pre-write value.
			if (rd_en && window_busy(model_acc[rd_sel], model_mode))
				exp_l <= 1'b1;  // set beats clear.
			else if (clr_l)
				exp_l <= 1'b0;
			if (set_scale)
				model_mode <= scale_in;
			if (op inside {OP_CLR, OP_LOAD, OP_MAC, OP_MSUB})
			begin
				model_acc[dst_sel] <= model_next;
				exp_e <= window_busy(model_next, model_mode);  // mode before this edge.
				exp_n <= model_next[AW-1];
				exp_z <= (model_next == '0);
			end
		end
	end

	a_valid: assert property (@(posedge clk) disable iff (!rst_n) rd_valid == exp_valid)
		else report_mismatch("rd_valid", {23'd0, $sampled(exp_valid)},
			{23'd0, $sampled(rd_valid)});
	a_data: assert property (@(posedge clk) disable iff (!rst_n) !exp_valid || rd_data == exp_data)
		else report_mismatch("rd_data", $sampled(exp_data), $sampled(rd_data));
	a_flag_l: assert property (@(posedge clk) disable iff (!rst_n) flag_l == exp_l)
		else report_mismatch("flag_l", {23'd0, $sampled(exp_l)}, {23'd0, $sampled(flag_l)});
	a_flag_e: assert property (@(posedge clk) disable iff (!rst_n) flag_e == exp_e)
		else report_mismatch("flag_e", {23'd0, $sampled(exp_e)}, {23'd0, $sampled(flag_e)});
	a_flag_n: assert property (@(posedge clk) disable iff (!rst_n) flag_n == exp_n)
		else report_mismatch("flag_n", {23'd0, $sampled(exp_n)}, {23'd0, $sampled(flag_n)});
	a_flag_z: assert property (@(posedge clk) disable iff (!rst_n) flag_z == exp_z)
		else report_mismatch("flag_z", {23'd0, $sampled(exp_z)}, {23'd0, $sampled(flag_z)});
	a_scale: assert property (@(posedge clk) disable iff (!rst_n) scale_mode == model_mode)
		else report_mismatch("scale_mode", {22'd0, $sampled(model_mode)},
			{22'd0, $sampled(scale_mode)});

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, stimulus never finished", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// one edge, then strobes back to idle.
	task automatic step();
		@(posedge clk);
		#1;
		op        = OP_NOP;
		set_scale = 1'b0;
		clr_l     = 1'b0;
		rd_en     = 1'b0;
	endtask

	task automatic command(input alu_op_t cmd, input logic dst, input word_t x, input word_t y);
		op      = cmd;
		dst_sel = dst;
		x_in    = x;
		y_in    = y;
		step();
	endtask

	task automatic read_word(input logic sel, input logic lsb);
		rd_en  = 1'b1;
		rd_sel = sel;
		rd_lsb = lsb;
		step();
	endtask

	task automatic set_mode(input scale_t mode);
		set_scale = 1'b1;
		scale_in  = mode;
		step();
	endtask

	initial
	begin
		errors    = 0;
		cycles    = 0;
		lfsr_q    = 16'd5905;  // seed.
		rst_n     = 1'b0;
		op        = OP_NOP;
		dst_sel   = 1'b0;
		x_in      = '0;
		y_in      = '0;
		set_scale = 1'b0;
		scale_in  = SCALE_NONE;
		clr_l     = 1'b0;
		rd_en     = 1'b0;
		rd_sel    = 1'b0;
		rd_lsb    = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// load returns x on the high word and zero on the low word, clear sets Z.
		command(OP_LOAD, 1'b0, rand_bits(24), '0);
		read_word(1'b0, 1'b0);
		read_word(1'b0, 1'b1);
		command(OP_CLR, 1'b0, '0, '0);
		step();

		// random mac and msub into A and B, extension stays clear.
		for (int i = 0; i < 24; i++)
		begin
			command(rand_bit() ? OP_MSUB : OP_MAC, rand_bit(), small_word(), small_word());
			read_word(rand_bit(), rand_bit());
		end

		// scale down, scale up, then reserved.
		for (int k = 1; k < 4; k++)
		begin
			set_mode(scale_t'(k));
			command(OP_LOAD, 1'b0, small_word(), '0);
			command(OP_MAC, 1'b0, rand_bits(24), small_word());
			read_word(1'b0, 1'b0);
			read_word(1'b0, 1'b1);
		end
		set_mode(SCALE_NONE);

		// positive saturation in A, negative in B.
		command(OP_LOAD, 1'b0, 24'h7fffff, '0);
		repeat (3) command(OP_MAC, 1'b0, 24'h7fffff, 24'h7fffff);
		read_word(1'b0, 1'b0);
		read_word(1'b0, 1'b1);
		command(OP_LOAD, 1'b1, 24'h800000, '0);
		repeat (3) command(OP_MSUB, 1'b1, 24'h7fffff, 24'h7fffff);
		read_word(1'b1, 1'b0);
		read_word(1'b1, 1'b1);

		// L holds through a clean read, clears, then a limiting read beats clr_l.
		command(OP_CLR, 1'b0, '0, '0);
		read_word(1'b0, 1'b0);
		clr_l = 1'b1;
		step();
		clr_l = 1'b1;
		read_word(1'b1, 1'b0);
		clr_l = 1'b1;
		step();

		// read and mac on A at the same edge see the old value.
		command(OP_LOAD, 1'b0, small_word(), '0);
		for (int j = 0; j < 3; j++)
		begin
			op      = OP_MAC;
			dst_sel = 1'b0;
			x_in    = rand_bits(24);
			y_in    = rand_bits(24);
			read_word(1'b0, rand_bit());
		end
		step();
		step();  // last checks land here.

		$display("run finished: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* logic/data_alu.sv */
// ========================================
// data ALU slice top: two 56-bit accumulators, MAC and limiter.
// commands and reads are one-cycle strobes, no back-pressure.
// rd_data holds its last value while rd_valid is low.
// ========================================
`timescale 1ns/1ps

module data_alu (
	input  logic              clk,
	input  logic              rst_n,
	input  dalu_pkg::alu_op_t op,
	input  logic              dst_sel,
	input  dalu_pkg::word_t   x_in,
	input  dalu_pkg::word_t   y_in,
	input  logic              set_scale,
	input  dalu_pkg::scale_t  scale_in,
	input  logic              clr_l,
	input  logic              rd_en,
	input  logic              rd_sel,
	input  logic              rd_lsb,
	output dalu_pkg::word_t   rd_data,
	output logic              rd_valid,
	output logic              flag_l,
	output logic              flag_e,
	output logic              flag_n,
	output logic              flag_z,
	output dalu_pkg::scale_t  scale_mode
);
	import dalu_pkg::*;

	acc_t acc_a;     // current A.
	acc_t acc_b;     // current B.
	logic wr_en;     // write strobe.
	logic wr_sel;    // 0 for A, 1 for B.
	acc_t wr_value;  // next accumulator value.
	logic lim_hit;   // a requested read saturated.

	acc_rd_if rd_bus ();  // combinational read path.

	alu_mac u_alu_mac (
		.op       (op),
		.dst_sel  (dst_sel),
		.x_in     (x_in),
		.y_in     (y_in),
		.acc_a    (acc_a),
		.acc_b    (acc_b),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_value (wr_value)
	);

	accumulator_file u_acc_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_value (wr_value),
		.rd_sel   (rd_sel),
		.acc_a    (acc_a),
		.acc_b    (acc_b),
		.rd       (rd_bus.src)
	);

	status_reg u_status (
		.clk        (clk),
		.rst_n      (rst_n),
		.set_scale  (set_scale),
		.scale_in   (scale_in),
		.clr_l      (clr_l),
		.lim_hit    (lim_hit),
		.wr_en      (wr_en),
		.wr_value   (wr_value),
		.rd         (rd_bus.cfg),
		.flag_l     (flag_l),
		.flag_e     (flag_e),
		.flag_n     (flag_n),
		.flag_z     (flag_z),
		.scale_mode (scale_mode)
	);

	acc_limiter u_limiter (
		.rd (rd_bus.lim)
	);

	assign rd_bus.lsb = rd_lsb;  // word select straight from the port.
	assign lim_hit    = rd_bus.limited & rd_en;  // only real reads set L.

	// valid follows rd_en one edge later.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_en;
		end
	end

	// data word captured only on a read.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= rd_bus.data;
		end
	end

endmodule

/* logic/status_reg.sv */
// ========================================
// scaling mode, sticky limit flag and E, N, Z flags.
// E uses the mode held at the write edge. a limiting read beats clr_l.
// ========================================
`timescale 1ns/1ps
`include "dalu_settings.svh"

module status_reg (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             set_scale,
	input  dalu_pkg::scale_t scale_in,
	input  logic             clr_l,
	input  logic             lim_hit,
	input  logic             wr_en,
	input  dalu_pkg::acc_t   wr_value,
	acc_rd_if.cfg            rd,
	output logic             flag_l,
	output logic             flag_e,
	output logic             flag_n,
	output logic             flag_z,
	output dalu_pkg::scale_t scale_mode
);
	import dalu_pkg::*;

	scale_t mode_q;  // scaling mode.

	// mode register, loaded by a strobe.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mode_q <= SCALE_NONE;
		end
		else if (set_scale)
		begin
			mode_q <= scale_in;
		end
	end

	// sticky limit, set takes priority over clear.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			flag_l <= 1'b0;
		end
		else if (lim_hit)
		begin
			flag_l <= 1'b1;
		end
		else if (clr_l)
		begin
			flag_l <= 1'b0;
		end
	end

	// result flags follow the last written accumulator.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			flag_e <= 1'b0;
			flag_n <= 1'b0;
			flag_z <= 1'b0;
		end
		else if (wr_en)
		begin
			flag_e <= ext_in_use(wr_value, mode_q);  // old mode if set_scale coincides.
			flag_n <= wr_value[`DALU_ACC_W-1];  // bit 55.
			flag_z <= (wr_value == '0);
		end
	end

	assign rd.mode    = mode_q;  // read path uses the held mode.
	assign scale_mode = mode_q;

endmodule

/* logic/acc_limiter.sv */
// ========================================
// moves an accumulator onto the 24-bit bus.
// saturates when the extension window is in use, else shifts
// by the scaling mode. reserved mode acts as no scaling.
// ========================================
`timescale 1ns/1ps
`include "dalu_settings.svh"

module acc_limiter (
	acc_rd_if.lim rd
);
	import dalu_pkg::*;

	localparam int unsigned ACC_MSB = `DALU_ACC_W - 1;  // sign bit.
	localparam int unsigned HI_LSB  = `DALU_WORD_W;     // first bit of the high word.

	logic  sign;      // accumulator sign.
	logic  sat;       // extension window in use.
	word_t hi_word;   // scaled high word.
	word_t lo_word;   // scaled low word.
	word_t sat_word;  // saturation constant.

	assign sign = rd.acc[ACC_MSB];
	assign sat  = ext_in_use(rd.acc, rd.mode);  // same window as the E flag.

	// slice position follows the scaling mode.
	always_comb
	begin
		case (rd.mode)
			SCALE_DOWN:
			begin
				hi_word = rd.acc[HI_LSB+`DALU_WORD_W : HI_LSB+1];  // 48..25.
				lo_word = rd.acc[`DALU_WORD_W : 1];  // 24..1.
			end
			SCALE_UP:
			begin
				hi_word = rd.acc[HI_LSB+`DALU_WORD_W-2 : HI_LSB-1];  // 46..23.
				lo_word = {rd.acc[`DALU_WORD_W-2 : 0], 1'b0};  // 22..0, zero in.
			end
			default:
			begin
				hi_word = rd.acc[HI_LSB+`DALU_WORD_W-1 : HI_LSB];  // 47..24.
				lo_word = rd.acc[`DALU_WORD_W-1 : 0];  // 23..0.
			end
		endcase
	end

	// limit values by sign and word.
	always_comb
	begin
		if (rd.lsb)
		begin
			sat_word = sign ? {`DALU_WORD_W{1'b0}} : {`DALU_WORD_W{1'b1}};  // 000000 / ffffff.
		end
		else
		begin
			sat_word = {sign, {(`DALU_WORD_W-1){~sign}}};  // 800000 / 7fffff.
		end
	end

	always_comb
	begin
		rd.limited = sat;  // set on every path.
		if (sat)
		begin
			rd.data = sat_word;
		end
		else if (rd.lsb)
		begin
			rd.data = lo_word;
		end
		else
		begin
			rd.data = hi_word;
		end
	end

endmodule

/* logic/accumulator_file.sv */
// ========================================
// accumulators A and B, one write and one read per cycle.
// the read is combinational and so sees the value
// from before a write at the same edge.
// ========================================
`timescale 1ns/1ps

module accumulator_file (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           wr_en,
	input  logic           wr_sel,
	input  dalu_pkg::acc_t wr_value,
	input  logic           rd_sel,
	output dalu_pkg::acc_t acc_a,
	output dalu_pkg::acc_t acc_b,
	acc_rd_if.src          rd
);
	import dalu_pkg::*;

	acc_t acc_a_q;  // accumulator A.
	acc_t acc_b_q;  // accumulator B.

	// the architectural state clears on reset.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc_a_q <= '0;
			acc_b_q <= '0;
		end
		else if (wr_en)
		begin
			if (wr_sel)
			begin
				acc_b_q <= wr_value;  // B written.
			end
			else
			begin
				acc_a_q <= wr_value;  // A written.
			end
		end
	end

	assign acc_a = acc_a_q;  // back to the mac for the next command.
	assign acc_b = acc_b_q;

	// read port: 0 picks A, 1 picks B.
	assign rd.acc = rd_sel ? acc_b_q : acc_a_q;

endmodule

/* logic/alu_mac.sv */
// ========================================
// next accumulator value for each command. combinational.
// product is x*y shifted left once, so -1 * -1 reaches the extension.
// sums wrap at 56 bits.
// ========================================
`timescale 1ns/1ps
`include "dalu_settings.svh"

module alu_mac (
	input  dalu_pkg::alu_op_t op,
	input  logic              dst_sel,
	input  dalu_pkg::word_t   x_in,
	input  dalu_pkg::word_t   y_in,
	input  dalu_pkg::acc_t    acc_a,
	input  dalu_pkg::acc_t    acc_b,
	output logic              wr_en,
	output logic              wr_sel,
	output dalu_pkg::acc_t    wr_value
);
	import dalu_pkg::*;

	acc_t                           acc_src;    // destination's current value.
	logic signed [`DALU_PROD_W-1:0] prod_int;   // integer product.
	logic signed [`DALU_PROD_W:0]   prod_frac;  // fractional alignment.
	logic signed [`DALU_ACC_W-1:0]  prod_ext;   // sign-extended to 56 bits.
	acc_t                           load_val;   // x placed in the high word.

	assign acc_src = dst_sel ? acc_b : acc_a;  // destination doubles as source.

	assign prod_int  = $signed(x_in) * $signed(y_in);  // 48-bit signed.
	assign prod_frac = {prod_int, 1'b0};  // drop the redundant sign bit.
	assign prod_ext  = prod_frac;  // signed assign extends the sign.

	// sign extension fills the top byte.
	assign load_val.ext = {`DALU_EXT_W{x_in[`DALU_WORD_W-1]}};
	assign load_val.hi  = x_in;
	assign load_val.lo  = {`DALU_WORD_W{1'b0}};  // low word cleared.

	assign wr_sel = dst_sel;  // write goes back to the source.

	always_comb
	begin
		wr_en    = 1'b1;     // every real command writes.
		wr_value = acc_src;  // holds value on nop.
		case (op)
			OP_CLR:
			begin
				wr_value = '0;
			end
			OP_LOAD:
			begin
				wr_value = load_val;
			end
			OP_MAC:
			begin
				wr_value = acc_src + prod_ext;  // wraps at 56 bits.
			end
			OP_MSUB:
			begin
				wr_value = acc_src - prod_ext;
			end
			default:
			begin
				wr_en = 1'b0;  // nop and unused codes.
			end
		endcase
	end

endmodule

/* logic/acc_rd_if.sv */
// ========================================
// one accumulator read through the limiter.
// purely combinational, no handshake.
// ========================================
`timescale 1ns/1ps

interface acc_rd_if;
	import dalu_pkg::*;

	acc_t   acc;      // selected accumulator.
	scale_t mode;     // scaling mode in force.
	logic   lsb;      // 1 selects the low word.
	word_t  data;     // limited and scaled word.
	logic   limited;  // saturation applied.

	// accumulator file drives the value.
	modport src (output acc);

	// status block drives the mode.
	modport cfg (output mode);

	modport lim (
		input  acc,
		input  mode,
		input  lsb,
		output data,
		output limited
	);

	// top level picks the word and takes the result.
	modport mon (
		output lsb,
		input  data,
		input  limited
	);

endinterface

/* logic/dalu_pkg.sv */
// ========================================
// types of the data ALU slice and the extension test shared by the
// limiter and the status block. needs dalu_settings.svh on the
// include path.
// ========================================
`include "dalu_settings.svh"

package dalu_pkg;

	typedef logic [`DALU_WORD_W-1:0] word_t;  // one data bus word.

	typedef struct packed {
		logic [`DALU_EXT_W-1:0] ext;  // extension, bits 55..48.
		word_t                  hi;   // most significant word, bits 47..24.
		word_t                  lo;   // least significant word, bits 23..0.
	} acc_t;

	typedef enum logic [`DALU_SCALE_W-1:0] {
		SCALE_NONE = 2'b00,  // no shift.
		SCALE_DOWN = 2'b01,  // shift right one place.
		SCALE_UP   = 2'b10,  // shift left one place.
		SCALE_RSVD = 2'b11   // treated as no scaling.
	} scale_t;

	typedef enum logic [`DALU_OP_W-1:0] {
		OP_NOP  = 3'd0,  // no write.
		OP_CLR  = 3'd1,  // clear accumulator.
		OP_LOAD = 3'd2,  // load x into the high word.
		OP_MAC  = 3'd3,  // add fractional product.
		OP_MSUB = 3'd4   // subtract fractional product.
	} alu_op_t;

	// true when the window below the sign is neither all zeros nor all ones.
	function automatic logic ext_in_use(input acc_t acc, input scale_t mode);
		logic [`DALU_EXT_W:0]   win_none;  // bits 55..47.
		logic [`DALU_EXT_W-1:0] win_down;  // bits 55..48.
		logic [`DALU_EXT_W+1:0] win_up;    // bits 55..46.
		logic                   in_use;
		win_none = acc[`DALU_ACC_W-1 -: `DALU_EXT_W+1];
		win_down = acc[`DALU_ACC_W-1 -: `DALU_EXT_W];
		win_up   = acc[`DALU_ACC_W-1 -: `DALU_EXT_W+2];
		case (mode)
			SCALE_DOWN: in_use = !((&win_down) || !(|win_down));  // one more bit shifts in.
			SCALE_UP:   in_use = !((&win_up) || !(|win_up));  // bit 46 moves to the top.
			default:    in_use = !((&win_none) || !(|win_none));  // none and reserved.
		endcase
		return in_use;
	endfunction

endpackage

/* logic/dalu_settings.svh */
// ========================================
// fixed field widths of the data ALU slice.
// these follow the 24-bit core and are not meant to be changed.
// ========================================
`ifndef DALU_SETTINGS_SVH
`define DALU_SETTINGS_SVH

// data bus word, also the width of the x and y operands.
`define DALU_WORD_W 24

// extension byte on top of the two accumulator words.
`define DALU_EXT_W 8

// full accumulator: extension, high word, low word.
`define DALU_ACC_W 56

// raw signed product of two data words.
`define DALU_PROD_W 48

// scaling mode field of the status register.
`define DALU_SCALE_W 2

// command field of the ALU.
`define DALU_OP_W 3

`endif
